// ==== all.f ====
logic/socPkg.sv
logic/resetStretcher.sv
logic/byteSwapInstr.sv
logic/microDelayInstr.sv
logic/busArbiter.sv
logic/or1420Fabric.sv
verification/fabric_chk.sv
verification/fabricTb.sv

// ==== logic/busArbiter.sv ====
`timescale 1ns/1ns

module busArbiter #(
  parameter int numberOfMasters = 4,
  parameter int busTimeoutCycles = 16
) (
  input  logic                       s_systemClock,
  input  logic                       s_pllLocked,
  input  logic                       systemReset,
  input  logic [numberOfMasters-1:0] busRequests,
  input  logic                       beginTransaction,
  input  logic                       endTransactionIn,
  input  logic                       dataValid,
  output logic [numberOfMasters-1:0] busGrants,
  output logic                       busIdle,
  output logic                       busError,
  output logic                       endTransactionOut
);

  localparam int watchdogWidth = $clog2(busTimeoutCycles + 1);
  localparam logic [watchdogWidth-1:0] lastSilentCount = watchdogWidth'(busTimeoutCycles - 1);

  logic [numberOfMasters-1:0] grantReg;
  logic [numberOfMasters-1:0] priorityGrant;
  logic [watchdogWidth-1:0]   watchdogCount;
  logic                       grantActive;
  logic                       silentCycle;
  logic                       releaseGrant;
  logic                       timeoutReg;

  assign grantActive = |grantReg;
  assign silentCycle = grantActive & ~beginTransaction & ~dataValid;
  // the watchdog end also frees the bus even if the end pulse is not fed back
  assign releaseGrant = endTransactionIn | timeoutReg;

  // highest requesting index wins, later iterations overwrite earlier ones
  always_comb begin
    priorityGrant = '0;
    for (int index = 0; index < numberOfMasters; index++) begin
      if (busRequests[index]) begin
        priorityGrant = '0;
        priorityGrant[index] = 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      grantReg <= '0;
    end else if (systemReset) begin
      grantReg <= '0;
    end else if (grantActive) begin
      if (releaseGrant) begin
        grantReg <= '0; // rearbitration waits one more edge
      end
    end else begin
      grantReg <= priorityGrant;
    end
  end

  // counts edges on which the granted master stays quiet
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      watchdogCount <= '0;
    end else if (systemReset | ~silentCycle | releaseGrant) begin
      watchdogCount <= '0;
    end else begin
      watchdogCount <= watchdogCount + 1'b1;
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      timeoutReg <= 1'b0;
    end else if (systemReset) begin
      timeoutReg <= 1'b0;
    end else begin
      timeoutReg <= silentCycle & ~releaseGrant & (watchdogCount == lastSilentCount);
    end
  end

  assign busGrants = grantReg;
  assign busIdle = ~grantActive;
  assign busError = timeoutReg; // error and end always pulse together
  assign endTransactionOut = timeoutReg;

endmodule

// ==== logic/byteSwapInstr.sv ====
`timescale 1ns/1ns

module byteSwapInstr import socPkg::*; #(
  parameter logic [ciIdWidth-1:0] customInstructionId = swapBytesId
) (
  input  logic                 systemReset,
  input  logic                 ciStart,
  input  logic [ciIdWidth-1:0] ciN,
  input  logic [dataWidth-1:0] ciDataA,
  input  logic [dataWidth-1:0] ciDataB,
  output logic                 ciDone,
  output ciWord_t              ciResult
);

  ciWord_t operand;
  ciWord_t swapped;
  logic selected;

  assign selected = ciStart & (ciN == customInstructionId) & ~systemReset;

  always_comb begin
    operand.word = ciDataA;
    if (ciDataB[0]) begin
      // swap inside each halfword
      swapped.bytes = {operand.bytes[2], operand.bytes[3], operand.bytes[0], operand.bytes[1]};
    end else begin
      // full endian reversal
      swapped.bytes = {operand.bytes[0], operand.bytes[1], operand.bytes[2], operand.bytes[3]};
    end
  end

  // answers in the start cycle, silent otherwise so the top can OR results
  always_comb begin
    ciDone = selected;
    ciResult.word = selected ? swapped.word : '0;
  end

endmodule

// ==== logic/microDelayInstr.sv ====
`timescale 1ns/1ns

module microDelayInstr import socPkg::*; #(
  parameter logic [ciIdWidth-1:0] customInstructionId = microDelayId,
  parameter int cyclesPerMicrosecond = 4
) (
  input  logic                 s_systemClock,
  input  logic                 s_pllLocked,
  input  logic                 systemReset,
  input  logic                 ciStart,
  input  logic [ciIdWidth-1:0] ciN,
  input  logic [dataWidth-1:0] ciDataA,
  output logic                 ciDone,
  output logic [dataWidth-1:0] ciResult
);

  localparam int prescaleWidth = (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] prescaleReload = prescaleWidth'(cyclesPerMicrosecond - 1);

  logic                     busy;
  logic                     doneReg;
  logic [prescaleWidth-1:0] prescaleCount;
  logic [dataWidth-1:0]     microCount;
  logic                     startDelay;
  logic                     microTick;
  logic                     countExhausted;

  assign startDelay = ciStart & (ciN == customInstructionId) & ~busy; // busy drops new starts
  assign microTick = (prescaleCount == '0);
  assign countExhausted = (microCount == '0);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      busy <= 1'b0;
      doneReg <= 1'b0;
      prescaleCount <= '0;
      microCount <= '0;
    end else if (systemReset) begin
      busy <= 1'b0;
      doneReg <= 1'b0;
      prescaleCount <= '0;
      microCount <= '0;
    end else begin
      doneReg <= 1'b0;
      if (startDelay) begin
        busy <= 1'b1;
        microCount <= ciDataA;
        prescaleCount <= prescaleReload;
      end else if (busy) begin
        if (countExhausted) begin
          // one extra edge after the last tick before answering
          busy <= 1'b0;
          doneReg <= 1'b1;
        end else if (microTick) begin
          microCount <= microCount - 1'b1;
          prescaleCount <= prescaleReload;
        end else begin
          prescaleCount <= prescaleCount - 1'b1;
        end
      end
    end
  end

  assign ciDone = doneReg;
  assign ciResult = '0; // the delay returns no value

endmodule

// ==== logic/or1420Fabric.sv ====
`timescale 1ns/1ns

module or1420Fabric import socPkg::*; #(
  parameter int cyclesPerMicrosecond = 4,
  parameter int numberOfMasters = 4,
  parameter int busTimeoutCycles = 16
) (
  input  logic                       s_systemClock,
  input  logic                       s_pllLocked,
  input  logic                       ciStart,
  input  logic [ciIdWidth-1:0]       ciN,
  input  logic [dataWidth-1:0]       ciDataA,
  input  logic [dataWidth-1:0]       ciDataB,
  input  logic [numberOfMasters-1:0] busRequests,
  input  logic                       beginTransaction,
  input  logic                       endTransactionIn,
  input  logic                       dataValid,
  output logic                       systemReset,
  output logic                       ciDone,
  output logic [dataWidth-1:0]       ciResult,
  output logic [numberOfMasters-1:0] busGrants,
  output logic                       busIdle,
  output logic                       busError,
  output logic                       endTransaction
);

  logic                 swapDone;
  ciWord_t              swapResult;
  logic                 delayDone;
  logic [dataWidth-1:0] delayResult;
  logic                 arbiterEndTransaction;

  resetStretcher resetStretch (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .systemReset(systemReset)
  );

  // every CI unit sees the same strobe, opcode and operands
  byteSwapInstr #(
    .customInstructionId(swapBytesId)
  ) swapBytes (
    .systemReset(systemReset),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciDone(swapDone),
    .ciResult(swapResult)
  );

  microDelayInstr #(
    .customInstructionId(microDelayId),
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) microDelay (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .systemReset(systemReset),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDone(delayDone),
    .ciResult(delayResult)
  );

  // idle units drive zero, so a plain OR merges the answers
  assign ciDone = swapDone | delayDone;
  assign ciResult = swapResult.word | delayResult;

  busArbiter #(
    .numberOfMasters(numberOfMasters),
    .busTimeoutCycles(busTimeoutCycles)
  ) arbiter (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .systemReset(systemReset),
    .busRequests(busRequests),
    .beginTransaction(beginTransaction),
    .endTransactionIn(endTransactionIn),
    .dataValid(dataValid),
    .busGrants(busGrants),
    .busIdle(busIdle),
    .busError(busError),
    .endTransactionOut(arbiterEndTransaction)
  );

  assign endTransaction = endTransactionIn | arbiterEndTransaction; // masters plus watchdog end

endmodule

// ==== logic/resetStretcher.sv ====
`timescale 1ns/1ns

module resetStretcher import socPkg::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  logic [resetCountWidth-1:0] resetCount;
  logic countDone;

  assign countDone = resetCount[resetCountWidth-1];

  // restarts whenever the pll drops lock, then freezes once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      resetCount <= '0;
    end else if (~countDone) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign systemReset = ~countDone; // held high for 2**(width-1) edges after lock

endmodule

// ==== logic/socPkg.sv ====
package socPkg;

  // custom instruction bus widths
  localparam int dataWidth = 32;
  localparam int ciIdWidth = 8;

  // instruction ids on ciN
  localparam logic [ciIdWidth-1:0] swapBytesId = 8'd1;
  localparam logic [ciIdWidth-1:0] microDelayId = 8'd6;

  // top bit of the counter releases the system reset, so 16 cycles
  localparam int resetCountWidth = 5;

  // one CI word, seen whole or as four bytes (byte 0 is the lsb)
  typedef union packed {
    logic [dataWidth-1:0] word;
    logic [3:0][7:0] bytes;
  } ciWord_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fabricTb \
  -f all.f -o fabricTbSim

status=0
./obj_dir/fabricTbSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a pass"
  exit 1
fi
echo "simulation passed"

// ==== verification/fabricTb.sv ====
`timescale 1ns/1ns

module fabricTb import socPkg::*; ();

  localparam int cyclesPerMicrosecond = 4;
  localparam int numberOfMasters = 4;
  localparam int busTimeoutCycles = 16;
  localparam int stretchEdges = 2 ** (resetCountWidth - 1);

  logic                       s_systemClock;
  logic                       s_pllLocked;
  logic                       ciStart;
  logic [ciIdWidth-1:0]       ciN;
  logic [dataWidth-1:0]       ciDataA;
  logic [dataWidth-1:0]       ciDataB;
  logic [numberOfMasters-1:0] busRequests;
  logic                       beginTransaction;
  logic                       endTransactionIn;
  logic                       dataValid;
  logic                       systemReset;
  logic                       ciDone;
  logic [dataWidth-1:0]       ciResult;
  logic [numberOfMasters-1:0] busGrants;
  logic                       busIdle;
  logic                       busError;
  logic                       endTransaction;

  or1420Fabric #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond),
    .numberOfMasters(numberOfMasters),
    .busTimeoutCycles(busTimeoutCycles)
  ) DUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .busRequests(busRequests),
    .beginTransaction(beginTransaction),
    .endTransactionIn(endTransactionIn),
    .dataValid(dataValid),
    .systemReset(systemReset),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .busGrants(busGrants),
    .busIdle(busIdle),
    .busError(busError),
    .endTransaction(endTransaction)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #2 s_systemClock = ~s_systemClock;
  end

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
    assert (actual === expected) else begin
      abortRun($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic clearInputs();
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    busRequests = '0;
    beginTransaction = 1'b0;
    endTransactionIn = 1'b0;
    dataValid = 1'b0;
  endtask

  // reverse all bytes, or swap inside each halfword
  function automatic logic [31:0] expectedSwap(ciWord_t value, logic halfwordMode);
    ciWord_t result;
    if (halfwordMode) begin
      result.bytes[0] = value.bytes[1];
      result.bytes[1] = value.bytes[0];
      result.bytes[2] = value.bytes[3];
      result.bytes[3] = value.bytes[2];
    end else begin
      result.bytes[0] = value.bytes[3];
      result.bytes[1] = value.bytes[2];
      result.bytes[2] = value.bytes[1];
      result.bytes[3] = value.bytes[0];
    end
    return result.word;
  endfunction

  function automatic logic [numberOfMasters-1:0] highestRequester(
    logic [numberOfMasters-1:0] requests
  );
    logic [numberOfMasters-1:0] grant;
    grant = '0;
    for (int index = numberOfMasters - 1; index >= 0; index--) begin
      if (requests[index] && grant == '0) begin
        grant[index] = 1'b1;
      end
    end
    return grant;
  endfunction

  // lock was raised on a falling edge, so each falling edge follows one rising edge
  task automatic waitForRelease();
    int edges;
    edges = 0;
    while (systemReset) begin
      if (edges > 4 * stretchEdges) abortRun("system reset never released after lock");
      @(negedge s_systemClock);
      edges++;
      if (edges == stretchEdges - 2) clearInputs(); // traffic stops before the release
    end
    compareValue("reset edges", edges, stretchEdges);
  endtask

  task automatic checkByteSwaps(int count);
    ciWord_t operand;
    logic [dataWidth-1:0] modeWord;
    for (int index = 0; index < count; index++) begin
      operand.word = $urandom();
      modeWord = $urandom();
      modeWord[0] = index[0]; // alternate both modes
      ciStart = 1'b1;
      ciN = swapBytesId;
      ciDataA = operand.word;
      ciDataB = modeWord;
      #1;
      compareValue("ciDone", ciDone, 1);
      compareValue("ciResult", ciResult, expectedSwap(operand, modeWord[0]));
      @(negedge s_systemClock);
      ciStart = 1'b0;
      @(negedge s_systemClock);
    end
  endtask

  task automatic measureDelay(logic [31:0] micros);
    int expectedEdges;
    int edges;
    expectedEdges = micros * cyclesPerMicrosecond + 1;
    edges = 0;
    ciStart = 1'b1;
    ciN = microDelayId;
    ciDataA = micros;
    ciDataB = $urandom();
    @(negedge s_systemClock); // start sampled
    ciStart = 1'b0;
    while (!ciDone) begin
      if (edges > expectedEdges + 8) abortRun("delay instruction never answered");
      @(negedge s_systemClock);
      edges++;
      ciStart = (edges == 2 && micros > 0); // restart while busy must be ignored
      ciDataA = 32'd50;
    end
    ciStart = 1'b0;
    compareValue("delay edges", edges, expectedEdges);
    compareValue("ciResult", ciResult, 0);
    repeat (expectedEdges + 8) begin
      @(negedge s_systemClock);
      compareValue("ciDone", ciDone, 0);
    end
  endtask

  task automatic probeUnknownOpcode(logic [ciIdWidth-1:0] opcode);
    ciStart = 1'b1;
    ciN = opcode;
    ciDataA = $urandom();
    ciDataB = $urandom();
    #1;
    compareValue("ciDone", ciDone, 0);
    compareValue("ciResult", ciResult, 0);
    repeat (40) begin
      @(negedge s_systemClock);
      ciStart = 1'b0;
      compareValue("ciDone", ciDone, 0);
      compareValue("ciResult", ciResult, 0);
    end
  endtask

  task automatic arbitrateRequests(logic [numberOfMasters-1:0] requests, int holdCycles);
    logic [numberOfMasters-1:0] expectedGrant;
    expectedGrant = highestRequester(requests);
    busRequests = requests;
    @(negedge s_systemClock); // grant follows one edge after the request
    compareValue("busGrants", busGrants, expectedGrant);
    compareValue("busIdle", busIdle, 0);
    busRequests = '0;
    beginTransaction = 1'b1;
    for (int cycle = 0; cycle < holdCycles; cycle++) begin
      @(negedge s_systemClock);
      beginTransaction = 1'b0;
      dataValid = 1'b1;
      compareValue("busGrants", busGrants, expectedGrant);
      compareValue("busError", busError, 0);
    end
    dataValid = 1'b0;
    endTransactionIn = 1'b1;
    #1;
    compareValue("endTransaction", endTransaction, 1);
    @(negedge s_systemClock);
    endTransactionIn = 1'b0;
    compareValue("busGrants", busGrants, 0);
    compareValue("busIdle", busIdle, 1);
  endtask

  task automatic starveWatchdog();
    int silentEdges;
    busRequests = 4'b0010;
    @(negedge s_systemClock);
    compareValue("busGrants", busGrants, 4'b0010);
    busRequests = '0;
    silentEdges = 0;
    while (!busError) begin
      if (silentEdges > busTimeoutCycles + 8) abortRun("watchdog never flagged the silent master");
      @(negedge s_systemClock);
      silentEdges++;
    end
    compareValue("silent edges", silentEdges, busTimeoutCycles);
    compareValue("endTransaction", endTransaction, 1);
    compareValue("busGrants", busGrants, 4'b0010);
    @(negedge s_systemClock);
    compareValue("busError", busError, 0);
    compareValue("busGrants", busGrants, 0);
    compareValue("busIdle", busIdle, 1);
  endtask

  initial begin
    void'($urandom(32'h6558070a));
    clearInputs();
    s_pllLocked = 1'b0;
    repeat (2) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    // a live start and requests while reset is stretched, all must stay unanswered
    ciStart = 1'b1;
    ciN = swapBytesId;
    ciDataA = $urandom();
    busRequests = '1;
    waitForRelease();
    checkByteSwaps(16);
    measureDelay(0);
    measureDelay(1);
    measureDelay(2);
    measureDelay(3);
    measureDelay($urandom_range(6, 1));
    probeUnknownOpcode(8'h00);
    probeUnknownOpcode(8'h2a);
    arbitrateRequests(4'b1111, 3 * busTimeoutCycles); // long enough for the watchdog
    arbitrateRequests(4'b0001, 1);
    repeat (6) arbitrateRequests($urandom_range(15, 1), $urandom_range(10, 1));
    starveWatchdog();
    @(negedge s_systemClock);
    if (DUT.fabricChecker.failureCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/fabric_chk.sv ====
`timescale 1ns/1ns

module fabricChk import socPkg::*; #(
  parameter int numberOfMasters = 4
) (
  input logic                       s_systemClock,
  input logic                       s_pllLocked,
  input logic                       systemReset,
  input logic                       ciDone,
  input logic                       delayDone,
  input logic [numberOfMasters-1:0] busGrants,
  input logic                       busIdle,
  input logic                       busError,
  input logic                       endTransaction
);

  localparam int stretchEdges = 2 ** (resetCountWidth - 1);

  logic [resetCountWidth:0] lockedEdges; // rising edges since lock, saturating
  int failureCount = 0; // failed assertions so far

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      lockedEdges <= '0;
    end else if (~lockedEdges[resetCountWidth]) begin
      lockedEdges <= lockedEdges + 1'b1;
    end
  end

  stretchLength: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    systemReset == (lockedEdges < stretchEdges))
    else begin
      failureCount++;
      $error("system reset does not last %0d edges after lock", stretchEdges);
    end

  quietInReset: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    systemReset |-> (~ciDone && ~busError && busGrants == '0 && busIdle))
    else begin
      failureCount++;
      $error("fabric outputs active while system reset is high");
    end

  grantOneHot: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    $onehot0(busGrants))
    else begin
      failureCount++;
      $error("more than one bus grant active");
    end

  idleMatchesGrant: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    busIdle == (busGrants == '0))
    else begin
      failureCount++;
      $error("bus idle disagrees with the grant vector");
    end

  // watchdog end comes with its error flag
  errorEndsTransaction: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    busError |-> endTransaction)
    else begin
      failureCount++;
      $error("bus error without end of transaction");
    end

  errorSingleCycle: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    busError |=> ~busError)
    else begin
      failureCount++;
      $error("bus error held longer than one cycle");
    end

  delayDoneSingleCycle: assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    delayDone |=> ~delayDone)
    else begin
      failureCount++;
      $error("delay done held longer than one cycle");
    end

endmodule

bind or1420Fabric fabricChk #(
  .numberOfMasters(numberOfMasters)
) fabricChecker (
  .s_systemClock(s_systemClock),
  .s_pllLocked(s_pllLocked),
  .systemReset(systemReset),
  .ciDone(ciDone),
  .delayDone(delayDone),
  .busGrants(busGrants),
  .busIdle(busIdle),
  .busError(busError),
  .endTransaction(endTransaction)
);
